// ==== hdl/matvec_cfg.svh ====
`ifndef MATVEC_CFG_SVH
`define MATVEC_CFG_SVH

// memory address width, both read memories and the result memory
`define MV_ADDR_W 12

// memory word width
// also the width of one result
`define MV_DATA_W 16

// largest matrix dimension N
// sizes the input word buffer
`define MV_MAX_N 16

// row / column index width
// needs to hold N itself, not only N-1
`define MV_IDX_W 5

// header layout per memory
//   word 0    N
//   word 1    element width in bits
//   word 2..  packed elements, msb field first

`endif

// ==== hdl/matvec_pkg.sv ====
`default_nettype none

`include "matvec_cfg.svh"

package matvec_pkg;

   // plain vectors with a meaning
   typedef logic [`MV_ADDR_W-1:0] addr_t;
   typedef logic [`MV_DATA_W-1:0] word_t;
   typedef logic [`MV_IDX_W-1:0]  idx_t;

   // element width code
   // 0 -> 2 bits, 1 -> 4 bits, 2 -> 8 bits, 3 -> 16 bits
   typedef logic [1:0] elem_w_t;

   // job geometry, captured from the two headers
   typedef struct packed {
      idx_t    n;
      elem_w_t in_w;
      elem_w_t wt_w;
      idx_t    row_words;
      idx_t    in_words;
   } layout_t;

   // one multiply-accumulate term
   typedef struct packed {
      logic valid;
      logic first;
      logic last;
      idx_t row;
   } mac_op_t;

   // result memory write port
   typedef struct packed {
      logic  en;
      addr_t addr;
      word_t data;
   } wr_port_t;

   typedef enum logic [2:0] {
      IDLE,
      HDR0,
      HDR1,
      LOAD_IN,
      FETCH_W,
      MAC_RUN,
      DRAIN
   } ctrl_state_t;

   // header width word to code, unknown widths fall back to 16
   function automatic elem_w_t width_code(word_t hdr);
      case (hdr)
         word_t'(2):  return 2'd0;
         word_t'(4):  return 2'd1;
         word_t'(8):  return 2'd2;
         default:     return 2'd3;
      endcase
   endfunction

endpackage

`default_nettype wire

// ==== hdl/matvec_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module matvec_ctrl (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                run,
   input  matvec_pkg::word_t   in_rd_data,
   input  matvec_pkg::word_t   wt_rd_data,
   output logic                busy,
   output matvec_pkg::addr_t   in_rd_addr,
   output matvec_pkg::addr_t   wt_rd_addr,
   output matvec_pkg::layout_t layout,
   output logic                in_load,
   output logic                wt_load,
   output logic                wt_step,
   output matvec_pkg::idx_t    col,
   output matvec_pkg::mac_op_t op
);
   import matvec_pkg::*;

   ctrl_state_t state;
   ctrl_state_t state_nxt;
   // last row drained with its write one cycle out
   logic        done_q;
   logic        start;
   // input words taken so far
   idx_t        cnt;
   idx_t        row;
   // fields still to step in the current weight word
   idx_t        fld_left;
   idx_t        fld_per_wd;
   elem_w_t     in_code;
   elem_w_t     wt_code;
   logic        row_end;
   logic        word_end;

   // run only counts when fully idle
   assign start = (state == IDLE) && !busy && run;

   // width codes straight off the bus during HDR1
   assign in_code = width_code(in_rd_data);
   assign wt_code = width_code(wt_rd_data);

   // 16/width fields in one weight word
   assign fld_per_wd = idx_t'(1) << (2'd3 - layout.wt_w);
   assign word_end   = (fld_left == '0);
   assign row_end    = (col == layout.n - 1'b1);

   // strobes decoded from state
   assign in_load = (state == LOAD_IN);
   assign wt_load = (state == FETCH_W);
   assign wt_step = (state == MAC_RUN);

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE:    if (start) state_nxt = HDR0;
         HDR0:    state_nxt = HDR1;
         HDR1:    state_nxt = LOAD_IN;
         LOAD_IN: if (cnt == layout.in_words - 1'b1) state_nxt = FETCH_W;
         FETCH_W: state_nxt = MAC_RUN;
         MAC_RUN: begin
            // row ends on a word boundary by the size rules
            if (row_end) begin
               state_nxt = DRAIN;
            end else if (word_end) begin
               state_nxt = FETCH_W;
            end
         end
         DRAIN:   state_nxt = (row == layout.n - 1'b1) ? IDLE : FETCH_W;
         default: state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state      <= IDLE;
         busy       <= 1'b0;
         done_q     <= 1'b0;
         in_rd_addr <= '0;
         wt_rd_addr <= '0;
         layout     <= '0;
         cnt        <= '0;
         row        <= '0;
         col        <= '0;
         fld_left   <= '0;
         op         <= '0;
      end else begin
         state  <= state_nxt;
         done_q <= 1'b0;
         // term issued one cycle behind its step so the product lands with it
         op <= '{valid: (state == MAC_RUN), first: (col == '0), last: row_end, row: row};
         case (state)
            IDLE: begin
               // address 0 sits on both buses while waiting
               in_rd_addr <= start ? addr_t'(1) : '0;
               wt_rd_addr <= start ? addr_t'(1) : '0;
               if (start) begin
                  busy <= 1'b1;
               end else if (done_q) begin
                  busy <= 1'b0;
               end
            end
            HDR0: begin
               layout.n   <= idx_t'(in_rd_data);
               in_rd_addr <= in_rd_addr + 1'b1;
               wt_rd_addr <= wt_rd_addr + 1'b1;
            end
            HDR1: begin
               layout.in_w      <= in_code;
               layout.wt_w      <= wt_code;
               // words = N*w/16
               layout.in_words  <= layout.n >> (2'd3 - in_code);
               layout.row_words <= layout.n >> (2'd3 - wt_code);
               in_rd_addr       <= in_rd_addr + 1'b1;
               cnt              <= '0;
               row              <= '0;
               col              <= '0;
            end
            LOAD_IN: begin
               in_rd_addr <= in_rd_addr + 1'b1;
               cnt        <= cnt + 1'b1;
            end
            FETCH_W: begin
               // next word read overlaps the field steps
               wt_rd_addr <= wt_rd_addr + 1'b1;
               fld_left   <= fld_per_wd - 1'b1;
            end
            MAC_RUN: begin
               col      <= col + 1'b1;
               fld_left <= fld_left - 1'b1;
            end
            DRAIN: begin
               row <= row + 1'b1;
               col <= '0;
               if (row == layout.n - 1'b1) begin
                  done_q <= 1'b1;
               end
            end
            default: ;
         endcase
      end
   end

   // every input word is in before the first weight step
   a_load_step_excl: assert property (@(posedge clk) disable iff (!arst_n)
      wt_step |-> (!in_load && (cnt == layout.in_words)));

   // both memories describe the same N
   a_hdr_n_match: assert property (@(posedge clk) disable iff (!arst_n)
      (state == HDR0) |-> (in_rd_data == wt_rd_data));

   // weight pointer advances by one row of words per finished row
   a_row_words: assert property (@(posedge clk) disable iff (!arst_n)
      (state == DRAIN) |->
         (wt_rd_addr == addr_t'(2) + addr_t'(row + 1'b1) * addr_t'(layout.row_words)));

endmodule

`default_nettype wire

// ==== hdl/matvec_input_buf.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "matvec_cfg.svh"

module matvec_input_buf (
   input  logic                clk,
   input  logic                arst_n,
   input  matvec_pkg::layout_t layout,
   input  logic                in_load,
   input  matvec_pkg::word_t   in_rd_data,
   input  matvec_pkg::idx_t    col,
   output matvec_pkg::word_t   in_elem
);
   import matvec_pkg::*;

   localparam int unsigned ptr_w = $clog2(`MV_MAX_N);

   // packed input words in load order
   word_t      mem [`MV_MAX_N];
   idx_t       wr_ptr;
   // elements per word
   idx_t       epw;
   idx_t       wsel;
   idx_t       fsel;
   // field width in bits
   logic [4:0] fw;
   logic [4:0] shamt;
   word_t      aligned;

   // pointer rewinds between bursts
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
      end else if (in_load) begin
         wr_ptr <= wr_ptr + 1'b1;
      end else begin
         wr_ptr <= '0;
      end
   end

   always_ff @(posedge clk) begin
      if (in_load) begin
         mem[wr_ptr[ptr_w-1:0]] <= in_rd_data;
      end
   end

   always_comb begin
      fw    = 5'd2 << layout.in_w;
      epw   = idx_t'(1) << (2'd3 - layout.in_w);
      // word holding element col, then its field slot
      wsel  = col >> (2'd3 - layout.in_w);
      fsel  = col & (epw - 1'b1);
      shamt = 5'(fsel * fw);
      // msb field first, so move the wanted one to the top
      aligned = mem[wsel[ptr_w-1:0]] << shamt;
      // zero-extend
      in_elem = aligned >> (5'd16 - fw);
   end

   a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
      in_load |-> (wr_ptr < idx_t'(`MV_MAX_N)));

endmodule

`default_nettype wire

// ==== hdl/matvec_weight_unpack.sv ====
`timescale 1ns/1ns
`default_nettype none

module matvec_weight_unpack (
   input  logic                clk,
   input  logic                arst_n,
   input  matvec_pkg::layout_t layout,
   input  logic                wt_load,
   input  logic                wt_step,
   input  matvec_pkg::word_t   wt_rd_data,
   output matvec_pkg::word_t   wt_elem
);
   import matvec_pkg::*;

   // current weight word, consumed from the top
   word_t      wd_q;
   // field width in bits
   logic [4:0] fw;

   assign fw = 5'd2 << layout.wt_w;

   always_ff @(posedge clk) begin
      if (wt_load) begin
         wd_q <= wt_rd_data;
      end else if (wt_step) begin
         // drop the field just used
         wd_q <= wd_q << fw;
      end
   end

   // top field, zero-extended
   // 16-bit code passes the word through
   assign wt_elem = wd_q >> (5'd16 - fw);

   // a step on the load cycle would skip field 0
   a_load_step_excl: assert property (@(posedge clk) disable iff (!arst_n)
      !(wt_load && wt_step));

endmodule

`default_nettype wire

// ==== hdl/matvec_mac.sv ====
`timescale 1ns/1ns
`default_nettype none

module matvec_mac (
   input  logic                 clk,
   input  logic                 arst_n,
   input  matvec_pkg::mac_op_t  op,
   input  matvec_pkg::word_t    in_elem,
   input  matvec_pkg::word_t    wt_elem,
   output matvec_pkg::wr_port_t res_wr
);
   import matvec_pkg::*;

   // product of the fields seen on the step cycle
   word_t prod_q;
   word_t acc_q;
   word_t sum;
   logic  wr_en_q;
   addr_t wr_addr_q;
   word_t wr_data_q;

   // first term restarts the row, wraps mod 2^16
   assign sum = (op.first ? '0 : acc_q) + prod_q;

   always_ff @(posedge clk) begin
      prod_q <= word_t'(in_elem * wt_elem);
      if (op.valid) begin
         acc_q <= sum;
      end
      if (op.valid && op.last) begin
         wr_addr_q <= addr_t'(op.row);
         wr_data_q <= sum;
      end
   end

   // one write per row, the cycle after the last term
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_en_q <= 1'b0;
      end else begin
         wr_en_q <= op.valid && op.last;
      end
   end

   assign res_wr = '{en: wr_en_q, addr: wr_addr_q, data: wr_data_q};

   // rows are at least one term plus a drain apart
   a_wr_single: assert property (@(posedge clk) disable iff (!arst_n)
      res_wr.en |=> !res_wr.en);

endmodule

`default_nettype wire

// ==== hdl/matvec_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module matvec_top (
   input  logic                 clk,
   input  logic                 arst_n,
   input  logic                 run,
   input  matvec_pkg::word_t    in_rd_data,
   input  matvec_pkg::word_t    wt_rd_data,
   output logic                 busy,
   output matvec_pkg::addr_t    in_rd_addr,
   output matvec_pkg::addr_t    wt_rd_addr,
   output matvec_pkg::wr_port_t res_wr
);
   import matvec_pkg::*;

   // controller to datapath
   layout_t layout;
   logic    in_load;
   logic    wt_load;
   logic    wt_step;
   idx_t    col;
   mac_op_t op;
   // selected operands
   word_t   in_elem;
   word_t   wt_elem;

   matvec_ctrl u_ctrl (
      .clk        (clk),
      .arst_n     (arst_n),
      .run        (run),
      .in_rd_data (in_rd_data),
      .wt_rd_data (wt_rd_data),
      .busy       (busy),
      .in_rd_addr (in_rd_addr),
      .wt_rd_addr (wt_rd_addr),
      .layout     (layout),
      .in_load    (in_load),
      .wt_load    (wt_load),
      .wt_step    (wt_step),
      .col        (col),
      .op         (op)
   );

   matvec_input_buf u_input_buf (
      .clk        (clk),
      .arst_n     (arst_n),
      .layout     (layout),
      .in_load    (in_load),
      .in_rd_data (in_rd_data),
      .col        (col),
      .in_elem    (in_elem)
   );

   matvec_weight_unpack u_weight_unpack (
      .clk        (clk),
      .arst_n     (arst_n),
      .layout     (layout),
      .wt_load    (wt_load),
      .wt_step    (wt_step),
      .wt_rd_data (wt_rd_data),
      .wt_elem    (wt_elem)
   );

   matvec_mac u_mac (
      .clk     (clk),
      .arst_n  (arst_n),
      .op      (op),
      .in_elem (in_elem),
      .wt_elem (wt_elem),
      .res_wr  (res_wr)
   );

endmodule

`default_nettype wire

// ==== verif/matvec_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "matvec_cfg.svh"

module matvec_tb;
   import matvec_pkg::*;

   // cycle allowance per job, N=0 for the idle check
   function automatic int cycle_budget(int n);
      return 2 * n * n + 4 * n + 20;
   endfunction

   localparam int max_cycles = 2 * (cycle_budget(0) + cycle_budget(16) + cycle_budget(8)
      + cycle_budget(4) + 2 * cycle_budget(8));
   localparam int mem_words = 1 << `MV_ADDR_W;

   logic        clk;
   logic        arst_n;
   logic        run;
   word_t       in_rd_data = '0;
   word_t       wt_rd_data = '0;
   logic        busy;
   addr_t       in_rd_addr;
   addr_t       wt_rd_addr;
   wr_port_t    res_wr;

   // read memory models
   word_t       in_mem [0:mem_words-1];
   word_t       wt_mem [0:mem_words-1];
   addr_t       in_addr_q = '0;
   addr_t       wt_addr_q = '0;

   // what the DUT wrote, per address
   word_t       res_mem [0:`MV_MAX_N-1];
   logic        hit [0:`MV_MAX_N-1];
   logic        stray_wr;
   int          wr_count;
   word_t       exp_res [0:`MV_MAX_N-1];
   // some row sum went past 16 bits
   logic        wrap_seen;
   int          cycles = 0;
   int unsigned seed;

   matvec_top uut (
      .clk        (clk),
      .arst_n     (arst_n),
      .run        (run),
      .in_rd_data (in_rd_data),
      .wt_rd_data (wt_rd_data),
      .busy       (busy),
      .in_rd_addr (in_rd_addr),
      .wt_rd_addr (wt_rd_addr),
      .res_wr     (res_wr)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // address taken on the rising edge
   // data shows up on the falling edge, seen by the DUT one cycle later
   always @(posedge clk) begin
      in_addr_q <= in_rd_addr;
      wt_addr_q <= wt_rd_addr;
   end

   always @(negedge clk) begin
      in_rd_data <= in_mem[in_addr_q];
      wt_rd_data <= wt_mem[wt_addr_q];
   end

   // result memory, sampled mid-cycle
   always @(negedge clk) begin
      if (arst_n && res_wr.en === 1'b1) begin
         wr_count = wr_count + 1;
         if (res_wr.addr < addr_t'(`MV_MAX_N)) begin
            res_mem[res_wr.addr] = res_wr.data;
            hit[res_wr.addr]     = 1'b1;
         end else begin
            stray_wr = 1'b1;
         end
      end
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > max_cycles) begin
         $display("timeout at %0t ns: run hung after %0d cycles", $time, cycles);
         stop_on_failure();
      end
   end

   task automatic stop_on_failure();
      $display("Test failed");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic report_error(string msg);
      $display("[ERROR] %0t ns: %s", $time, msg);
      stop_on_failure();
   endtask

   task automatic check_word(word_t got, word_t exp, string what);
      if (got !== exp) begin
         report_error($sformatf("%s: got %h, expected %h", what, got, exp));
      end
   endtask

   task automatic check_bit(logic got, logic exp, string what);
      if (got !== exp) begin
         report_error($sformatf("%s: got %b, expected %b", what, got, exp));
      end
   endtask

   task automatic check_count(idx_t got, idx_t exp, string what);
      if (got !== exp) begin
         report_error($sformatf("%s: got %0d, expected %0d", what, got, exp));
      end
   endtask

   // header width word to bits, anything unknown reads as 16
   function automatic int elem_bits(word_t hdr);
      if (hdr == 16'd2 || hdr == 16'd4 || hdr == 16'd8) begin
         return int'(hdr);
      end else begin
         return 16;
      end
   endfunction

   // slot 0 is the most significant field
   function automatic word_t field_of(word_t wd, int bits, int slot);
      word_t mask;
      mask = word_t'((32'd1 << bits) - 1);
      return (wd >> (16 - bits * (slot + 1))) & mask;
   endfunction

   // random contents, then the two header words
   task automatic load_job(int n, int in_hdr, int wt_hdr);
      for (int a = 0; a < mem_words; a++) begin
         in_mem[a] = word_t'($urandom);
         wt_mem[a] = word_t'($urandom);
      end
      in_mem[0] = word_t'(n);
      in_mem[1] = word_t'(in_hdr);
      wt_mem[0] = word_t'(n);
      wt_mem[1] = word_t'(wt_hdr);
   endtask

   // reference sums straight from the memory images
   task automatic compute_expected(int n);
      int     in_bits;
      int     wt_bits;
      int     row_words;
      word_t  x;
      word_t  w;
      longint full;
      in_bits   = elem_bits(in_mem[1]);
      wt_bits   = elem_bits(wt_mem[1]);
      row_words = n * wt_bits / 16;
      wrap_seen = 1'b0;
      for (int i = 0; i < n; i++) begin
         full = 0;
         for (int j = 0; j < n; j++) begin
            x = field_of(in_mem[2 + j / (16 / in_bits)], in_bits, j % (16 / in_bits));
            w = field_of(wt_mem[2 + i * row_words + j / (16 / wt_bits)], wt_bits,
               j % (16 / wt_bits));
            full = full + longint'(x) * longint'(w);
         end
         exp_res[i] = word_t'(full);
         if (full > 65535) begin
            wrap_seen = 1'b1;
         end
      end
   endtask

   task automatic clear_results();
      wr_count = 0;
      stray_wr = 1'b0;
      for (int i = 0; i < `MV_MAX_N; i++) begin
         res_mem[i] = '0;
         hit[i]     = 1'b0;
      end
   endtask

   // one-cycle run pulse, busy expected right after
   task automatic start_run();
      @(negedge clk);
      run = 1'b1;
      @(negedge clk);
      run = 1'b0;
      check_bit(busy, 1'b1, "busy after run");
   endtask

   task automatic wait_idle();
      while (busy !== 1'b0) begin
         @(negedge clk);
      end
   endtask

   task automatic check_results(int n, string tag);
      check_count(idx_t'(wr_count), idx_t'(n), {tag, " write count"});
      check_bit(stray_wr, 1'b0, {tag, " write outside 0..N-1"});
      for (int i = 0; i < n; i++) begin
         check_bit(hit[i], 1'b1, $sformatf("%s row %0d written", tag, i));
         check_word(res_mem[i], exp_res[i], $sformatf("%s row %0d sum", tag, i));
      end
   endtask

   task automatic run_job(int n, int in_hdr, int wt_hdr, string tag);
      load_job(n, in_hdr, wt_hdr);
      clear_results();
      compute_expected(n);
      start_run();
      wait_idle();
      check_results(n, tag);
   endtask

   task automatic test_idle_after_reset();
      clear_results();
      check_bit(busy, 1'b0, "busy after reset");
      check_bit(res_wr.en, 1'b0, "write enable after reset");
      repeat (10) begin
         @(negedge clk);
         check_bit(busy, 1'b0, "busy with run low");
      end
      check_count(idx_t'(wr_count), '0, "writes with run low");
   endtask

   task automatic test_wrap_with_fallback();
      // width 5 is out of range, treated as 16
      run_job(4, 16, 5, "n4 w16/w5");
      check_bit(wrap_seen, 1'b1, "n4 sums past 16 bits");
   endtask

   task automatic test_run_during_busy();
      load_job(8, 8, 8);
      clear_results();
      compute_expected(8);
      start_run();
      // run held high for a while mid-job
      @(negedge clk);
      run = 1'b1;
      repeat (5) @(negedge clk);
      check_bit(busy, 1'b1, "busy while run held");
      run = 1'b0;
      wait_idle();
      check_results(8, "held run");
      // fresh data, different widths
      run_job(8, 16, 4, "rerun");
   endtask

   initial begin
      run    = 1'b0;
      arst_n = 1'b0;
      seed   = 32'h94b6;
      void'($urandom(seed));
      repeat (5) @(negedge clk);
      arst_n = 1'b1;

      test_idle_after_reset();
      run_job(16, 8, 8, "n16 w8/w8");
      run_job(8, 4, 2, "n8 w4/w2");
      test_wrap_with_fallback();
      test_run_during_busy();

      $display("Test completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

// ==== matvec.f ====
+incdir+hdl
hdl/matvec_pkg.sv
hdl/matvec_ctrl.sv
hdl/matvec_input_buf.sv
hdl/matvec_weight_unpack.sv
hdl/matvec_mac.sv
hdl/matvec_top.sv
verif/matvec_tb.sv
